// File: videoAddressUnit.f
videoPkg.sv
refreshCounter.sv
matrixCounter.sv
spriteDma.sv
addressGen.sv
videoAddressUnit.sv
videoAddressUnit_tb.sv

// File: videoAddressUnit_tb.sv
// Table-driven testbench for the video address unit with a reference model of its counters

`timescale 1ns/1ns

module videoAddressUnit_tb import videoPkg::*; ;

	localparam int CLK_PERIOD  = 40;
	localparam int SEED        = 32'h1291;
	localparam int TABLE_DEPTH = 72;
	localparam int TIMEOUT     = TABLE_DEPTH * 2 + 50;

	// One table row holds every input the DUT sees in one slot
	typedef struct packed {
		vicCycle_t  cyc;
		logic       phi02, phis, leg, bmm, ecm;
		spriteNum_t spr;
		vicAddr_t   vm, cb;
		charCode_t  data;
		logic       done, lineEnd, frameStart;
	} row_t;

	logic clk33 = 1'b0, rstN, phi02, phis, leg, bmm, ecm, fetchDone, lineEnd, frameStart;
	vicCycle_t vicCycle;
	vicAddr_t vm, cb, vicAddr;
	spriteNum_t sprite;
	logic [7:0] sprite1;
	charCode_t dataIn;
	fetchKind_t fetchKind;

	row_t rows [TABLE_DEPTH];
	int nRows = 0;
	int seed = SEED;
	int errors = 0;
	int cycles = 0;
	vicAddr_t tvm, tcb;

	// Model state, written only from the counter and address rules
	refCount_t refRow;
	matrixIndex_t rowBase, ndx;
	scanline_t line;
	charCode_t chr;
	spritePtr_t ptrModel [MIBCNT];
	spriteCount_t cntModel [MIBCNT];
	vicAddr_t expAddr;
	fetchKind_t expKind;
	logic [2:0] expSprite;

	videoAddressUnit u_videoAddressUnit (
		.clk33, .rstN, .phi02, .phis, .leg, .bmm, .ecm, .vicCycle, .vm, .cb, .sprite,
		.sprite1, .fetchDone, .lineEnd, .frameStart, .dataIn, .vicAddr, .fetchKind
	);

	always #(CLK_PERIOD / 2) clk33 = ~clk33;

	// Watchdog sized from the table depth
	always @(posedge clk33) begin
		cycles++;
		if (cycles > TIMEOUT) begin
			$display("Run did not complete within %0d cycles", TIMEOUT);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// ======================================================================
	// Table and model helpers
	// ======================================================================

	// Phase bits are {phi02, phis}, mode bits {leg, bmm, ecm}, control {done, lineEnd, frameStart}
	task automatic addRow(input vicCycle_t c, input logic [1:0] ph, input logic [2:0] md,
			input spriteNum_t s, input logic [2:0] ctl);
		charCode_t d;
		d = $random(seed);
		rows[nRows] = {c, ph, md, s, tvm, tcb, d, ctl};
		nRows++;
	endtask

	task automatic applyRow(input row_t r);
		vicCycle = r.cyc;
		phi02 = r.phi02;
		phis = r.phis;
		leg = r.leg;
		bmm = r.bmm;
		ecm = r.ecm;
		sprite = r.spr;
		vm = r.vm;
		cb = r.cb;
		dataIn = r.data;
		fetchDone = r.done;
		lineEnd = r.lineEnd;
		frameStart = r.frameStart;
	endtask

	// Expected address and kind for one slot, from the counters before the edge
	task automatic predictFetch(input row_t r, output vicAddr_t a, output fetchKind_t f);
		a = 14'h3FFF;
		f = FETCH_NONE;
		if (r.cyc == VIC_REF || (r.cyc == VIC_RC && !r.phi02)) begin
			a = {6'h3F, refRow};
			f = FETCH_REF;
		end else if ((r.cyc == VIC_RC || r.cyc == VIC_CHAR || r.cyc == VIC_G) && r.phi02) begin
			a = r.vm + {3'd0, ndx};
			f = FETCH_MATRIX;
		end else if (r.cyc == VIC_CHAR || r.cyc == VIC_G) begin
			f = FETCH_CHAR;
			a = r.bmm ? {r.cb[13], 13'd0} + {ndx, line} : {r.cb[13:11], chr[7:0], line};
			if (r.ecm)
				a[10:9] = 2'b00;
		end else if (r.cyc == VIC_SPRITE) begin
			// Pointer slot in either layout, data slot otherwise
			if (r.leg ? (!r.phi02 && sprite1[4]) : r.phis) begin
				f = FETCH_SPRPTR;
				if (r.leg)
					a = r.vm + (14'h3F8 | {11'd0, r.spr[2:0]});
				else
					a = r.vm + (14'h3F0 | {10'd0, ~r.spr[3], r.spr[2:0]});
			end else begin
				f = FETCH_SPRDATA;
				a = {ptrModel[r.spr[2:0]], cntModel[r.spr[2:0]]};
			end
		end
	endtask

	// One clock edge of the model, completions refer to the kind registered before it
	task automatic stepModel(input row_t r);
		vicAddr_t a;
		fetchKind_t f;
		predictFetch(r, a, f);
		if (r.frameStart) begin
			refRow = 8'hFF;
			rowBase = '0;
			ndx = '0;
			line = '0;
		end else begin
			if (r.done && expKind == FETCH_REF)
				refRow = refRow - 8'd1;
			if (r.lineEnd) begin
				if (line == 3'd7)
					rowBase = rowBase + 11'd40;
				ndx = rowBase;
				line = line + 3'd1;
			end else if (r.done && expKind == FETCH_MATRIX) begin
				ndx = ndx + 11'd1;
			end
		end
		if (r.done && expKind == FETCH_MATRIX)
			chr = r.data;
		if (r.done && expKind == FETCH_SPRPTR) begin
			ptrModel[expSprite] = r.data[7:0];
			cntModel[expSprite] = '0;
		end else if (r.done && expKind == FETCH_SPRDATA) begin
			cntModel[expSprite] = cntModel[expSprite] + 6'd1;
		end
		expAddr = a;
		expKind = f;
		expSprite = r.spr[2:0];
	endtask

	task automatic checkOutputs();
		if (vicAddr !== expAddr) begin
			errors++;
			$display("FAILED vicAddr expected %h actual %h", expAddr, vicAddr);
		end
		if (fetchKind !== expKind) begin
			errors++;
			$display("FAILED fetchKind expected %h actual %h", expKind, fetchKind);
		end
	endtask

	// ======================================================================
	// Stimulus
	// ======================================================================

	initial begin
		spriteNum_t spr;
		spriteNum_t firstSpr;
		row_t idleRow;
		idleRow = '0;
		sprite1 = 8'h10;
		rstN = 1'b0;
		applyRow(idleRow);
		refRow = 8'hFF;
		rowBase = '0;
		ndx = '0;
		line = '0;
		chr = '0;
		for (int i = 0; i < MIBCNT; i++) begin
			ptrModel[i] = '0;
			cntModel[i] = '0;
		end
		expAddr = 14'h3FFF;
		expKind = FETCH_NONE;
		expSprite = '0;

		// Refresh rows, then the two halves of a refresh slot shared with the matrix
		tvm = 14'h0400;
		tcb = 14'h1000;
		addRow(VIC_REF, 2'b00, 3'b000, 4'd0, 3'b000);
		repeat (3) addRow(VIC_REF, 2'b00, 3'b000, 4'd0, 3'b100);
		addRow(VIC_RC, 2'b00, 3'b000, 4'd0, 3'b100);
		addRow(VIC_RC, 2'b10, 3'b000, 4'd0, 3'b100);
		// Text mode matrix and glyph reads, ecm on every other glyph
		for (int k = 0; k < 3; k++) begin
			addRow(VIC_CHAR, 2'b10, 3'b000, 4'd0, 3'b000);
			addRow(VIC_IDLE, 2'b00, 3'b000, 4'd0, 3'b100);
			addRow(VIC_CHAR, 2'b00, {2'b00, k[0]}, 4'd0, 3'b000);
		end
		// Bitmap reads
		tvm = 14'h2C00;
		tcb = 14'h2000;
		for (int k = 0; k < 3; k++) begin
			addRow(VIC_G, 2'b10, 3'b010, 4'd0, 3'b000);
			addRow(VIC_IDLE, 2'b00, 3'b010, 4'd0, 3'b100);
			addRow(VIC_G, 2'b00, {2'b01, k[0]}, 4'd0, 3'b000);
		end
		// Legacy pointer fetch followed by a walk through the data bytes
		spr = $random(seed);
		firstSpr = spr;
		addRow(VIC_SPRITE, 2'b00, 3'b100, spr, 3'b000);
		repeat (4) addRow(VIC_SPRITE, 2'b10, 3'b100, spr, 3'b100);
		// Enhanced layout on another random slot, kept apart from the first one
		spr = $random(seed);
		if (spr[2:0] == firstSpr[2:0])
			spr[2:0] = firstSpr[2:0] + 3'd1;
		addRow(VIC_SPRITE, 2'b01, 3'b000, spr, 3'b000);
		repeat (3) addRow(VIC_SPRITE, 2'b00, 3'b000, spr, 3'b100);
		// The first sprite still holds its own pointer and byte count
		addRow(VIC_SPRITE, 2'b10, 3'b100, firstSpr, 3'b000);
		// Nine line ends cover one full character row and the start of the next
		tvm = 14'h0400;
		for (int k = 0; k < 9; k++) begin
			addRow(VIC_CHAR, 2'b10, 3'b000, 4'd0, 3'b000);
			addRow(VIC_CHAR, 2'b10, 3'b000, 4'd0, 3'b100);
			addRow(VIC_IDLE, 2'b00, 3'b000, 4'd0, 3'b010);
		end
		addRow(VIC_IDLE, 2'b00, 3'b000, 4'd0, 3'b001);
		// A new frame reads from the first cell and the first scanline again
		addRow(VIC_CHAR, 2'b10, 3'b000, 4'd0, 3'b000);
		addRow(VIC_CHAR, 2'b00, 3'b000, 4'd0, 3'b000);
		addRow(VIC_REF, 2'b00, 3'b000, 4'd0, 3'b000);
		addRow(VIC_REF, 2'b00, 3'b000, 4'd0, 3'b100);

		repeat (4) @(posedge clk33);
		#2;
		rstN = 1'b1;
		checkOutputs();
		for (int i = 0; i < nRows; i++) begin
			applyRow(rows[i]);
			@(posedge clk33);
			#2;
			stepModel(rows[i]);
			checkOutputs();
		end

		$display("Checked %0d rows, %0d errors", nRows, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: videoAddressUnit.sv
// Top level of the video address unit joining the counters and the address generator

`timescale 1ns/1ns

module videoAddressUnit import videoPkg::*; (
	input  logic       clk33,
	input  logic       rstN,
	input  logic       phi02,
	input  logic       phis,
	input  logic       leg,
	input  logic       bmm,
	input  logic       ecm,
	input  vicCycle_t  vicCycle,
	input  vicAddr_t   vm,
	input  vicAddr_t   cb,
	input  spriteNum_t sprite,
	input  logic [7:0] sprite1,
	// Memory side marks the end of the access in flight
	input  logic       fetchDone,
	input  logic       lineEnd,
	input  logic       frameStart,
	input  charCode_t  dataIn,
	output vicAddr_t   vicAddr,
	output fetchKind_t fetchKind
);

	// ======================================================================
	// Internal nets
	// ======================================================================

	logic [2:0]   fetchSprite;
	refCount_t    refcntr;
	matrixIndex_t vmndx;
	scanline_t    scanline;
	charCode_t    nextChar;
	spritePtr_t   mPtr [MIBCNT];
	spriteCount_t mCnt [MIBCNT];

	// ======================================================================
	// Instances
	// ======================================================================

	addressGen u_addressGen (
		.clk33, .rstN, .phi02, .phis, .leg, .bmm, .ecm, .vicCycle,
		.refcntr, .vm, .vmndx, .cb, .scanline, .nextChar, .sprite, .sprite1,
		.mCnt, .mPtr, .vicAddr, .fetchKind, .fetchSprite
	);

	refreshCounter u_refreshCounter (
		.clk33, .rstN, .frameStart, .fetchDone, .fetchKind, .refcntr
	);

	matrixCounter u_matrixCounter (
		.clk33, .rstN, .frameStart, .lineEnd, .fetchDone, .fetchKind, .dataIn,
		.vmndx, .scanline, .nextChar
	);

	spriteDma u_spriteDma (
		.clk33, .rstN, .fetchDone, .fetchKind, .fetchSprite, .dataIn,
		.mPtr, .mCnt
	);

endmodule

// File: addressGen.sv
// Registered video address multiplexer producing the address and fetch kind per slot

`timescale 1ns/1ns

module addressGen import videoPkg::*; (
	input  logic         clk33,
	input  logic         rstN,
	input  logic         phi02,
	input  logic         phis,
	// Legacy sprite pointer layout when high
	input  logic         leg,
	input  logic         bmm,
	input  logic         ecm,
	input  vicCycle_t    vicCycle,
	input  refCount_t    refcntr,
	input  vicAddr_t     vm,
	input  matrixIndex_t vmndx,
	input  vicAddr_t     cb,
	input  scanline_t    scanline,
	input  charCode_t    nextChar,
	input  spriteNum_t   sprite,
	input  logic [7:0]   sprite1,
	input  spriteCount_t mCnt [MIBCNT],
	input  spritePtr_t   mPtr [MIBCNT],
	output vicAddr_t     vicAddr,
	output fetchKind_t   fetchKind,
	output logic [2:0]   fetchSprite
);

	// ======================================================================
	// Address selection
	// ======================================================================

	vicAddr_t   addr;
	fetchKind_t kind;
	vicAddr_t   refAddr;
	vicAddr_t   matrixAddr;
	vicAddr_t   sprDataAddr;

	// Refresh rows sit in the top page of the 16K window
	assign refAddr     = {6'b111111, refcntr};
	assign matrixAddr  = vm + vicAddr_t'(vmndx);
	// Sprite data is the block pointer with the byte counter below it
	assign sprDataAddr = {mPtr[sprite[2:0]], mCnt[sprite[2:0]]};

	always_comb begin
		addr = 14'h3FFF;
		kind = FETCH_NONE;
		case (vicCycle)
			VIC_REF: begin
				addr = refAddr;
				kind = FETCH_REF;
			end
			VIC_RC: begin
				// The CPU half of a refresh slot is stolen for the matrix read
				if (phi02) begin
					addr = matrixAddr;
					kind = FETCH_MATRIX;
				end else begin
					addr = refAddr;
					kind = FETCH_REF;
				end
			end
			VIC_CHAR, VIC_G: begin
				if (phi02) begin
					addr = matrixAddr;
					kind = FETCH_MATRIX;
				end else begin
					kind = FETCH_CHAR;
					// Bitmap data is 8K aligned, text glyphs come from the character base
					if (bmm)
						addr = {cb[13], 13'd0} + {vmndx, scanline};
					else
						addr = {cb[13:11], nextChar[7:0], scanline};
					// Extended colour steals the top two code bits for background select
					if (ecm)
						addr[10:9] = 2'b00;
				end
			end
			VIC_SPRITE: begin
				if (leg) begin
					// Legacy pointers live in the last eight bytes of the matrix
					if (!phi02 && sprite1[4]) begin
						addr = vm + (14'h3F8 | {11'd0, sprite[2:0]});
						kind = FETCH_SPRPTR;
					end else begin
						addr = sprDataAddr;
						kind = FETCH_SPRDATA;
					end
				end else begin
					if (!phis) begin
						addr = sprDataAddr;
						kind = FETCH_SPRDATA;
					end else begin
						// Two banks of eight pointers, bank 0 at the higher address
						addr = vm + (14'h3F0 | {10'd0, ~sprite[3], sprite[2:0]});
						kind = FETCH_SPRPTR;
					end
				end
			end
			default: begin
				addr = 14'h3FFF;
				kind = FETCH_NONE;
			end
		endcase
	end

	// ======================================================================
	// Output registers
	// ======================================================================

	always_ff @(posedge clk33) begin
		if (!rstN) begin
			vicAddr     <= 14'h3FFF;
			fetchKind   <= FETCH_NONE;
			fetchSprite <= 3'd0;
		end else begin
			vicAddr     <= addr;
			fetchKind   <= kind;
			fetchSprite <= sprite[2:0];
		end
	end

	// The beam timing only ever hands down one of the six defined slot types
	assert property (@(posedge clk33) disable iff (!rstN)
		!$isunknown(vicCycle) && vicCycle <= VIC_SPRITE);

endmodule

// File: spriteDma.sv
// Sprite pointer registers and per-sprite data byte counters

`timescale 1ns/1ns

module spriteDma import videoPkg::*; (
	input  logic         clk33,
	input  logic         rstN,
	input  logic         fetchDone,
	input  fetchKind_t   fetchKind,
	input  logic [2:0]   fetchSprite,
	input  charCode_t    dataIn,
	output spritePtr_t   mPtr [MIBCNT],
	output spriteCount_t mCnt [MIBCNT]
);

	// ======================================================================
	// Fetch decode
	// ======================================================================

	logic ptrDone;
	logic dataDone;

	assign ptrDone  = fetchDone && (fetchKind == FETCH_SPRPTR);
	assign dataDone = fetchDone && (fetchKind == FETCH_SPRDATA);

	// ======================================================================
	// Per-sprite state
	// ======================================================================

	// Only the slot that was fetched changes, the others hold
	always_ff @(posedge clk33) begin
		if (!rstN) begin
			for (int i = 0; i < MIBCNT; i++) begin
				mPtr[i] <= '0;
				mCnt[i] <= '0;
			end
		end else if (ptrDone) begin
			// New block number, data reads start at its first byte
			mPtr[fetchSprite] <= dataIn[7:0];
			mCnt[fetchSprite] <= '0;
		end else if (dataDone) begin
			// Six bits, so the counter wraps at the end of the 64-byte block
			mCnt[fetchSprite] <= mCnt[fetchSprite] + 6'd1;
		end
	end

	// Sprite slot must be defined whenever a sprite access completes
	assert property (@(posedge clk33) disable iff (!rstN)
		(ptrDone || dataDone) |-> !$isunknown(fetchSprite));

endmodule

// File: matrixCounter.sv
// Video matrix index, row base, character scanline and fetched character latch

`timescale 1ns/1ns

module matrixCounter import videoPkg::*; (
	input  logic         clk33,
	input  logic         rstN,
	input  logic         frameStart,
	input  logic         lineEnd,
	input  logic         fetchDone,
	input  fetchKind_t   fetchKind,
	input  charCode_t    dataIn,
	output matrixIndex_t vmndx,
	output scanline_t    scanline,
	output charCode_t    nextChar
);

	// ======================================================================
	// Row tracking
	// ======================================================================

	// Forty cells to a text row
	localparam matrixIndex_t ROWSTEP = 11'd40;

	matrixIndex_t rowBase;
	matrixIndex_t nextBase;
	logic         matrixDone;
	logic         lastLine;

	assign matrixDone = fetchDone && (fetchKind == FETCH_MATRIX);
	assign lastLine   = (scanline == 3'd7);
	// The base only moves on after the eighth scanline of a row
	assign nextBase   = lastLine ? rowBase + ROWSTEP : rowBase;

	always_ff @(posedge clk33) begin
		if (!rstN) begin
			rowBase  <= '0;
			vmndx    <= '0;
			scanline <= '0;
		end else if (frameStart) begin
			// New frame starts from the first cell of the first row
			rowBase  <= '0;
			vmndx    <= '0;
			scanline <= '0;
		end else if (lineEnd) begin
			// Every line rereads the same row unless the row is finished
			rowBase  <= nextBase;
			vmndx    <= nextBase;
			scanline <= scanline + 3'd1;
		end else if (matrixDone) begin
			vmndx <= vmndx + 11'd1;
		end
	end

	// ======================================================================
	// Character latch
	// ======================================================================

	// Holds the code read on the matrix half for the following glyph read
	always_ff @(posedge clk33) begin
		if (!rstN)
			nextChar <= '0;
		else if (matrixDone)
			nextChar <= dataIn;
	end

	// The index walks no further than one text row past its base
	assert property (@(posedge clk33) disable iff (!rstN)
		{1'b0, vmndx} <= {1'b0, rowBase} + 12'd40);

endmodule

// File: refreshCounter.sv
// DRAM refresh row counter stepping down once per completed refresh fetch

`timescale 1ns/1ns

module refreshCounter import videoPkg::*; (
	input  logic       clk33,
	input  logic       rstN,
	input  logic       frameStart,
	input  logic       fetchDone,
	input  fetchKind_t fetchKind,
	output refCount_t  refcntr
);

	// ======================================================================
	// Row counter
	// ======================================================================

	logic refDone;

	// Only a finished refresh access moves the row on
	assign refDone = fetchDone && (fetchKind == FETCH_REF);

	always_ff @(posedge clk33) begin
		if (!rstN) begin
			refcntr <= 8'hFF;
		end else if (frameStart) begin
			// Each frame restarts at the top row
			refcntr <= 8'hFF;
		end else if (refDone) begin
			// Wraps from 00 back to FF
			refcntr <= refcntr - 8'd1;
		end
	end

endmodule

// File: videoPkg.sv
// Shared cycle and fetch enums, width typedefs and the sprite count for the video address unit

package videoPkg;

	// ======================================================================
	// Sizes
	// ======================================================================

	// Number of hardware sprites, one pointer and one byte counter each
	localparam int MIBCNT = 8;

	// ======================================================================
	// Width types
	// ======================================================================

	// Video memory address, 16K window seen by the controller
	typedef logic [13:0] vicAddr_t;
	// DRAM refresh row number
	typedef logic [7:0]  refCount_t;
	// Offset into the video matrix (1000 cells on screen)
	typedef logic [10:0] matrixIndex_t;
	// Scanline inside a character row
	typedef logic [2:0]  scanline_t;
	// Character code with its colour nibble on top
	typedef logic [11:0] charCode_t;
	// Sprite pointer, counts 64-byte blocks
	typedef logic [7:0]  spritePtr_t;
	// Byte offset inside a sprite block
	typedef logic [5:0]  spriteCount_t;
	// Sprite slot; bit 3 picks the upper pointer bank in enhanced mode
	typedef logic [3:0]  spriteNum_t;

	// ======================================================================
	// Enums
	// ======================================================================

	// Memory slot type as handed down by the beam timing
	typedef enum logic [2:0] {
		VIC_IDLE, VIC_REF, VIC_RC, VIC_CHAR, VIC_G, VIC_SPRITE
	} vicCycle_t;

	// What the registered address is being used for
	typedef enum logic [2:0] {
		FETCH_NONE, FETCH_REF, FETCH_MATRIX, FETCH_CHAR, FETCH_SPRPTR, FETCH_SPRDATA
	} fetchKind_t;

endpackage
